/* source/tile_mixer_pkg.sv */
package tile_mixer_pkg;

	////////////////////
	// shared widths
	////////////////////

	// pixels per tile slice, one bit per pixel in each plane
	localparam int TILE_PIX   = 4;
	// three bitplanes give a 3-bit dot
	localparam int DOT_W      = 3;
	// graphics word is plane 0 in 3:0, plane 1 in 7:4, plane 2 in 11:8
	localparam int GFX_W      = 12;
	localparam int ATTR_W     = 8;
	localparam int PRI_W      = 3;
	// two chips with layers A and B each
	localparam int NUM_LAYERS = 4;

	////////////////////
	// pixel and phase types
	////////////////////

	// one mixed pixel, dot of zero is transparent
	typedef struct packed {
		logic [PRI_W-1:0]  pri;
		logic [ATTR_W-1:0] color;
		logic [DOT_W-1:0]  dot;
	} pixel_t;

	// which layer takes the graphics word in the current cycle
	// value doubles as the layer index and the strobe bit number
	typedef enum logic [1:0] {
		phase_s0a = 2'd0,
		phase_s0b = 2'd1,
		phase_s1a = 2'd2,
		phase_s1b = 2'd3
	} load_phase_e;

endpackage

/* source/tile_load_if.sv */
`timescale 1ns/1ps

interface tile_load_if;
	import tile_mixer_pkg::*;

	// registered tile word, three planes side by side
	logic [GFX_W-1:0]      gfx;
	// colour attribute fetched together with the word
	logic [ATTR_W-1:0]     attr;
	// one-hot, bit n loads the layer of phase n
	logic [NUM_LAYERS-1:0] load;
	// direction for the slice group now loading
	logic                  flip;

	// sequencer side drives the whole bundle
	modport seq (
		output gfx,
		output attr,
		output load,
		output flip
	);

	// chip side only listens
	modport pair (
		input gfx,
		input attr,
		input load,
		input flip
	);

endinterface

/* source/load_sequencer.sv */
`timescale 1ns/1ps

module load_sequencer (
	input  logic                              CLK_6M,
	input  logic                              arst_n,
	input  logic [tile_mixer_pkg::GFX_W-1:0]  gfx_data,
	input  logic [tile_mixer_pkg::ATTR_W-1:0] attr_data,
	input  logic                              flip,
	tile_load_if.seq                          bus
);
	import tile_mixer_pkg::*;

	load_phase_e phase_q;
	load_phase_e phase_nxt;

	// four phase ring, one layer per cycle
	always_comb begin
		case (phase_q)
			phase_s0a: phase_nxt = phase_s0b;
			phase_s0b: phase_nxt = phase_s1a;
			phase_s1a: phase_nxt = phase_s1b;
			default:   phase_nxt = phase_s0a;
		endcase
	end

	////////////////////
	// phase and strobes
	////////////////////

	always_ff @(posedge CLK_6M or negedge arst_n) begin
		if (!arst_n) begin
			phase_q  <= phase_s0a;
			bus.load <= '0;
			bus.flip <= 1'b0;
		end else begin
			phase_q  <= phase_nxt;
			// strobe follows the word registered in the same edge
			bus.load <= NUM_LAYERS'(1) << phase_q;
			// direction only changes at a group boundary
			// layer s1b loads on the edge this updates, so it still sees the old value
			if (phase_q == phase_s0a) begin
				bus.flip <= flip;
			end
		end
	end

	// graphics and attribute bus capture
	always_ff @(posedge CLK_6M) begin
		bus.gfx  <= gfx_data;
		bus.attr <= attr_data;
	end

endmodule

/* source/plane_shifter.sv */
`timescale 1ns/1ps

module plane_shifter #(
	parameter int LOAD_DELAY = 0
) (
	input  logic                              CLK_6M,
	input  logic                              arst_n,
	input  logic                              load,
	input  logic [tile_mixer_pkg::GFX_W-1:0]  gfx,
	input  logic [tile_mixer_pkg::ATTR_W-1:0] attr,
	input  logic                              flip,
	input  logic [tile_mixer_pkg::PRI_W-1:0]  pri,
	output tile_mixer_pkg::pixel_t            pixel
);
	import tile_mixer_pkg::*;

	// far end of each plane, first pixel out when flipped
	localparam int MSB = TILE_PIX - 1;

	logic [DOT_W-1:0][TILE_PIX-1:0] plane_q;
	logic [ATTR_W-1:0]              color_q;
	logic                           flip_q;
	logic [DOT_W-1:0]               cur_dot;
	logic [DOT_W-1:0]               dly_dot;
	logic [ATTR_W-1:0]              dly_color;

	////////////////////
	// plane shift registers
	////////////////////

	always_ff @(posedge CLK_6M or negedge arst_n) begin
		if (!arst_n) begin
			plane_q <= '0;
			color_q <= '0;
			flip_q  <= 1'b0;
		end else if (load) begin
			// split the word into its three planes
			for (int i = 0; i < DOT_W; i++) begin
				plane_q[i] <= gfx[i*TILE_PIX +: TILE_PIX];
			end
			color_q <= attr;
			// direction is held for the whole slice
			flip_q  <= flip;
		end else begin
			// zeros shift in, so an idle layer goes transparent
			for (int i = 0; i < DOT_W; i++) begin
				plane_q[i] <= flip_q ? plane_q[i] << 1 : plane_q[i] >> 1;
			end
		end
	end

	// dot from the end that is shifting out
	always_comb begin
		for (int i = 0; i < DOT_W; i++) begin
			cur_dot[i] = flip_q ? plane_q[i][MSB] : plane_q[i][0];
		end
	end

	////////////////////
	// alignment delay
	////////////////////

	if (LOAD_DELAY == 0) begin : g_direct
		// last layer in the phase cycle needs no extra stages
		assign dly_dot   = cur_dot;
		assign dly_color = color_q;
	end else begin : g_delay
		logic [DOT_W-1:0]  dot_pipe   [LOAD_DELAY];
		logic [ATTR_W-1:0] color_pipe [LOAD_DELAY];

		always_ff @(posedge CLK_6M or negedge arst_n) begin
			if (!arst_n) begin
				for (int i = 0; i < LOAD_DELAY; i++) begin
					dot_pipe[i]   <= '0;
					color_pipe[i] <= '0;
				end
			end else begin
				dot_pipe[0]   <= cur_dot;
				color_pipe[0] <= color_q;
				for (int i = 1; i < LOAD_DELAY; i++) begin
					dot_pipe[i]   <= dot_pipe[i-1];
					color_pipe[i] <= color_pipe[i-1];
				end
			end
		end

		assign dly_dot   = dot_pipe[LOAD_DELAY-1];
		assign dly_color = color_pipe[LOAD_DELAY-1];
	end

	// priority is live, not delayed with the dot
	assign pixel = {pri, dly_color, dly_dot};

endmodule

/* source/priority_regs.sv */
`timescale 1ns/1ps

module priority_regs (
	input  logic                                                         CLK_6M,
	input  logic                                                         arst_n,
	input  logic                                                         reg_we,
	input  logic [1:0]                                                   reg_addr,
	input  logic [tile_mixer_pkg::ATTR_W-1:0]                            reg_data,
	output logic [tile_mixer_pkg::NUM_LAYERS-1:0][tile_mixer_pkg::PRI_W-1:0] layer_pri
);
	import tile_mixer_pkg::*;

	// one write select per layer register
	logic [NUM_LAYERS-1:0] wr_sel;

	////////////////////
	// address decode
	////////////////////

	// 0 pair 0 A, 1 pair 0 B, 2 pair 1 A, 3 pair 1 B
	always_comb begin
		wr_sel = '0;
		if (reg_we) begin
			wr_sel[reg_addr] = 1'b1;
		end
	end

	////////////////////
	// registers
	////////////////////

	for (genvar g = 0; g < NUM_LAYERS; g++) begin : g_pri
		always_ff @(posedge CLK_6M or negedge arst_n) begin
			if (!arst_n) begin
				layer_pri[g] <= '0;
			end else if (wr_sel[g]) begin
				// only the low bits carry a priority
				layer_pri[g] <= reg_data[PRI_W-1:0];
			end
		end
	end

endmodule

/* source/tilemap_pair.sv */
`timescale 1ns/1ps

module tilemap_pair #(
	parameter int DELAY_A = 0,
	parameter int DELAY_B = 0
) (
	input  logic                             CLK_6M,
	input  logic                             arst_n,
	tile_load_if.pair                        bus,
	input  logic                             load_a,
	input  logic                             load_b,
	input  logic [tile_mixer_pkg::PRI_W-1:0] pri_a,
	input  logic [tile_mixer_pkg::PRI_W-1:0] pri_b,
	input  tile_mixer_pkg::pixel_t           chain_in,
	output tile_mixer_pkg::pixel_t           chain_out
);
	import tile_mixer_pkg::*;

	pixel_t pix_a;
	pixel_t pix_b;
	pixel_t pair_win;

	// challenger wins only when opaque and strictly above the holder
	// a tie keeps the holder
	function automatic pixel_t pick(input pixel_t challenger, input pixel_t holder);
		if (challenger.dot != '0 && challenger.pri > holder.pri) begin
			return challenger;
		end
		return holder;
	endfunction

	////////////////////
	// layers
	////////////////////

	// layer A loads first in this chip's two phases
	plane_shifter #(
		.LOAD_DELAY (DELAY_A)
	) u_layer_a (
		.CLK_6M (CLK_6M),
		.arst_n (arst_n),
		.load   (load_a),
		.gfx    (bus.gfx),
		.attr   (bus.attr),
		.flip   (bus.flip),
		.pri    (pri_a),
		.pixel  (pix_a)
	);

	plane_shifter #(
		.LOAD_DELAY (DELAY_B)
	) u_layer_b (
		.CLK_6M (CLK_6M),
		.arst_n (arst_n),
		.load   (load_b),
		.gfx    (bus.gfx),
		.attr   (bus.attr),
		.flip   (bus.flip),
		.pri    (pri_b),
		.pixel  (pix_b)
	);

	////////////////////
	// priority mix
	////////////////////

	// B against A inside the chip
	assign pair_win  = pick(pix_b, pix_a);
	// chip winner against the pixel from up the chain
	assign chain_out = pick(pair_win, chain_in);

endmodule

/* source/tilemap_mixer_top.sv */
`timescale 1ns/1ps

module tilemap_mixer_top (
	input  logic                              CLK_6M,
	input  logic                              arst_n,
	input  logic [tile_mixer_pkg::GFX_W-1:0]  gfx_data,
	input  logic [tile_mixer_pkg::ATTR_W-1:0] attr_data,
	input  logic                              flip,
	input  logic [tile_mixer_pkg::PRI_W-1:0]  back_pri,
	input  logic [tile_mixer_pkg::ATTR_W-1:0] back_color,
	input  logic [tile_mixer_pkg::DOT_W-1:0]  back_dot,
	input  logic                              reg_we,
	input  logic [1:0]                        reg_addr,
	input  logic [tile_mixer_pkg::ATTR_W-1:0] reg_data,
	output logic [tile_mixer_pkg::PRI_W-1:0]  out_pri,
	output logic [tile_mixer_pkg::ATTR_W-1:0] out_color,
	output logic [tile_mixer_pkg::DOT_W-1:0]  out_dot
);
	import tile_mixer_pkg::*;

	// layer of phase p waits 3 - p stages so all four meet
	localparam int MAX_DELAY = NUM_LAYERS - 1;
	// bus register + shifter load + alignment, plus output register makes six
	localparam int BG_STAGES = MAX_DELAY + 2;

	tile_load_if u_load_bus ();

	logic [NUM_LAYERS-1:0][PRI_W-1:0] layer_pri;
	pixel_t                           bg_pipe [BG_STAGES];
	pixel_t                           chain_mid;
	pixel_t                           chain_end;
	pixel_t                           out_q;

	////////////////////
	// load path
	////////////////////

	load_sequencer u_load_sequencer (
		.CLK_6M    (CLK_6M),
		.arst_n    (arst_n),
		.gfx_data  (gfx_data),
		.attr_data (attr_data),
		.flip      (flip),
		.bus       (u_load_bus)
	);

	priority_regs u_priority_regs (
		.CLK_6M    (CLK_6M),
		.arst_n    (arst_n),
		.reg_we    (reg_we),
		.reg_addr  (reg_addr),
		.reg_data  (reg_data),
		.layer_pri (layer_pri)
	);

	////////////////////
	// background delay
	////////////////////

	// keeps the chain input in step with the layer pipeline
	always_ff @(posedge CLK_6M or negedge arst_n) begin
		if (!arst_n) begin
			for (int i = 0; i < BG_STAGES; i++) begin
				bg_pipe[i] <= '0;
			end
		end else begin
			bg_pipe[0] <= {back_pri, back_color, back_dot};
			for (int i = 1; i < BG_STAGES; i++) begin
				bg_pipe[i] <= bg_pipe[i-1];
			end
		end
	end

	////////////////////
	// chip chain
	////////////////////

	// first chip sees the background
	tilemap_pair #(
		.DELAY_A (MAX_DELAY - int'(phase_s0a)),
		.DELAY_B (MAX_DELAY - int'(phase_s0b))
	) u_pair0 (
		.CLK_6M    (CLK_6M),
		.arst_n    (arst_n),
		.bus       (u_load_bus),
		.load_a    (u_load_bus.load[phase_s0a]),
		.load_b    (u_load_bus.load[phase_s0b]),
		.pri_a     (layer_pri[phase_s0a]),
		.pri_b     (layer_pri[phase_s0b]),
		.chain_in  (bg_pipe[BG_STAGES-1]),
		.chain_out (chain_mid)
	);

	// second chip has the last word on the pixel
	tilemap_pair #(
		.DELAY_A (MAX_DELAY - int'(phase_s1a)),
		.DELAY_B (MAX_DELAY - int'(phase_s1b))
	) u_pair1 (
		.CLK_6M    (CLK_6M),
		.arst_n    (arst_n),
		.bus       (u_load_bus),
		.load_a    (u_load_bus.load[phase_s1a]),
		.load_b    (u_load_bus.load[phase_s1b]),
		.pri_a     (layer_pri[phase_s1a]),
		.pri_b     (layer_pri[phase_s1b]),
		.chain_in  (chain_mid),
		.chain_out (chain_end)
	);

	// output register after the combinational mix
	always_ff @(posedge CLK_6M or negedge arst_n) begin
		if (!arst_n) begin
			out_q <= '0;
		end else begin
			out_q <= chain_end;
		end
	end

	assign out_pri   = out_q.pri;
	assign out_color = out_q.color;
	assign out_dot   = out_q.dot;

endmodule

/* testbench/tb_tilemap_mixer.sv */
`timescale 1ns/1ps

module tb_tilemap_mixer;
	import tile_mixer_pkg::*;

	// group kinds of the schedule
	localparam int MODE_QUIET  = 0;
	localparam int MODE_RANDOM = 1;
	localparam int MODE_B_ZERO = 2;
	localparam int MODE_BG     = 3;
	// 300 groups of four cycles plus drain margin
	localparam int MAX_CYCLES  = 300 * 4 + 100;

	logic              CLK_6M;
	logic              arst_n;
	logic [GFX_W-1:0]  gfx_data;
	logic [ATTR_W-1:0] attr_data;
	logic              flip;
	logic [PRI_W-1:0]  back_pri;
	logic [ATTR_W-1:0] back_color;
	logic [DOT_W-1:0]  back_dot;
	logic              reg_we;
	logic [1:0]        reg_addr;
	logic [ATTR_W-1:0] reg_data;
	logic [PRI_W-1:0]  out_pri;
	logic [ATTR_W-1:0] out_color;
	logic [DOT_W-1:0]  out_dot;

	integer seed = 32'hcc7;
	int     cyc;
	int     in_cyc;
	// expected pixels in output order with their cycle numbers
	pixel_t exp_q [$];
	int     time_q [$];
	// priorities the DUT holds as written by the testbench
	logic [PRI_W-1:0] pri_shadow [NUM_LAYERS];

	tilemap_mixer_top u_tilemap_mixer_top (
		.CLK_6M     (CLK_6M),
		.arst_n     (arst_n),
		.gfx_data   (gfx_data),
		.attr_data  (attr_data),
		.flip       (flip),
		.back_pri   (back_pri),
		.back_color (back_color),
		.back_dot   (back_dot),
		.reg_we     (reg_we),
		.reg_addr   (reg_addr),
		.reg_data   (reg_data),
		.out_pri    (out_pri),
		.out_color  (out_color),
		.out_dot    (out_dot)
	);

	always #2 CLK_6M = ~CLK_6M;

	////////////////////
	// reference model
	////////////////////

	// pixel k of one layer slice where plane n gives dot bit n
	function automatic pixel_t slice_pixel(input logic [GFX_W-1:0] word,
			input logic [ATTR_W-1:0] attr, input logic [PRI_W-1:0] pri,
			input logic flp, input int k);
		int     idx;
		pixel_t p;
		idx = flp ? (TILE_PIX - 1 - k) : k;
		p.pri   = pri;
		p.color = attr;
		p.dot   = {word[2*TILE_PIX+idx], word[TILE_PIX+idx], word[idx]};
		return p;
	endfunction

	// B over A and then the winner over the chain
	// a challenger needs an opaque dot and a strictly higher priority
	function automatic pixel_t mix_ref(input pixel_t l0, input pixel_t l1,
			input pixel_t l2, input pixel_t l3, input pixel_t bg);
		pixel_t w0;
		pixel_t w1;
		pixel_t res;
		w0 = l0;
		if (l1.dot != 3'd0 && l1.pri > l0.pri) w0 = l1;
		res = bg;
		if (w0.dot != 3'd0 && w0.pri > res.pri) res = w0;
		w1 = l2;
		if (l3.dot != 3'd0 && l3.pri > l2.pri) w1 = l3;
		if (w1.dot != 3'd0 && w1.pri > res.pri) res = w1;
		return res;
	endfunction

	////////////////////
	// checking
	////////////////////

	task automatic check_value(input string name, input logic [31:0] got,
			input logic [31:0] exp);
		if (got !== exp) begin
			$display("mismatch at %0t: %s got %h expected %h", $time, name, got, exp);
			$display("Testbench failed");
			$fatal(1);
		end
	endtask

	task automatic compare_pixel(input pixel_t e);
		check_value("out_pri", 32'(out_pri), 32'(e.pri));
		check_value("out_color", 32'(out_color), 32'(e.color));
		check_value("out_dot", 32'(out_dot), 32'(e.dot));
	endtask

	// cycle number of the interval that ends at the next edge
	always @(posedge CLK_6M) begin
		if (arst_n) cyc <= cyc + 1;
	end

	// outputs are stable at the falling edge
	always @(negedge CLK_6M) begin
		if (cyc < 6) begin
			compare_pixel('0);
		end else if (time_q.size() != 0) begin
			if (time_q[0] != cyc) begin
				$display("expected pixel for cycle %0d is out of step at cycle %0d",
					time_q[0], cyc);
				$display("Testbench failed");
				$fatal(1);
			end
			compare_pixel(exp_q.pop_front());
			void'(time_q.pop_front());
		end
	end

	always @(posedge CLK_6M) begin
		if (cyc > MAX_CYCLES) begin
			$display("timeout: the run went past %0d cycles", MAX_CYCLES);
			$display("Testbench failed");
			$fatal(1);
		end
	end

	////////////////////
	// stimulus
	////////////////////

	// one input cycle that the DUT samples at the next edge
	task automatic drive_cycle(input logic [GFX_W-1:0] g, input logic [ATTR_W-1:0] a,
			input logic f, input pixel_t bg, input logic we, input logic [1:0] addr,
			input logic [ATTR_W-1:0] data);
		gfx_data   <= g;
		attr_data  <= a;
		flip       <= f;
		back_pri   <= bg.pri;
		back_color <= bg.color;
		back_dot   <= bg.dot;
		reg_we     <= we;
		reg_addr   <= addr;
		reg_data   <= data;
		@(posedge CLK_6M);
		in_cyc++;
	endtask

	// four words of one group, an optional priority rewrite, and its expected pixels
	task automatic run_group(input int mode, input bit wr,
			input logic [PRI_W-1:0] p0, input logic [PRI_W-1:0] p1,
			input logic [PRI_W-1:0] p2, input logic [PRI_W-1:0] p3);
		logic [GFX_W-1:0]  words [NUM_LAYERS];
		logic [ATTR_W-1:0] attrs [NUM_LAYERS];
		logic [PRI_W-1:0]  new_pri [NUM_LAYERS];
		pixel_t            bgs [TILE_PIX];
		logic              grp_flip;
		logic              f;
		logic [31:0]       r;
		int                c;
		new_pri[0] = p0;
		new_pri[1] = p1;
		new_pri[2] = p2;
		new_pri[3] = p3;
		grp_flip = 1'b0;
		c = in_cyc;
		for (int p = 0; p < NUM_LAYERS; p++) begin
			r = $random(seed);
			words[p] = r[GFX_W-1:0];
			attrs[p] = r[19:12];
			f = r[20];
			r = $random(seed);
			bgs[p].pri   = r[2:0];
			bgs[p].color = r[10:3];
			bgs[p].dot   = r[13:11];
			if (mode == MODE_QUIET || mode == MODE_BG) words[p] = '0;
			if (mode == MODE_B_ZERO && (p % 2) == 1) words[p] = '0;
			if (mode == MODE_QUIET) bgs[p] = '0;
			// only the phase 0 value of flip counts for the group
			if (p == 0) grp_flip = f;
			if (wr) begin
				pri_shadow[p] = new_pri[p];
				drive_cycle(words[p], attrs[p], f, bgs[p], 1'b1, 2'(p),
					{r[20:16], new_pri[p]});
			end else begin
				drive_cycle(words[p], attrs[p], f, bgs[p], 1'b0, 2'd0, 8'd0);
			end
		end
		for (int k = 0; k < TILE_PIX; k++) begin
			exp_q.push_back(mix_ref(
				slice_pixel(words[0], attrs[0], pri_shadow[0], grp_flip, k),
				slice_pixel(words[1], attrs[1], pri_shadow[1], grp_flip, k),
				slice_pixel(words[2], attrs[2], pri_shadow[2], grp_flip, k),
				slice_pixel(words[3], attrs[3], pri_shadow[3], grp_flip, k),
				bgs[k]));
			time_q.push_back(c + 6 + k);
		end
	endtask

	// three quiet groups with the priority rewrite in the middle one
	task automatic rewrite_priorities(input logic [PRI_W-1:0] p0,
			input logic [PRI_W-1:0] p1, input logic [PRI_W-1:0] p2,
			input logic [PRI_W-1:0] p3);
		run_group(MODE_QUIET, 1'b0, '0, '0, '0, '0);
		run_group(MODE_QUIET, 1'b1, p0, p1, p2, p3);
		run_group(MODE_QUIET, 1'b0, '0, '0, '0, '0);
	endtask

	task automatic repeat_groups(input int mode, input int n);
		for (int i = 0; i < n; i++) begin
			run_group(mode, 1'b0, '0, '0, '0, '0);
		end
	endtask

	initial begin
		CLK_6M     = 1'b0;
		arst_n     = 1'b0;
		gfx_data   = '0;
		attr_data  = '0;
		flip       = 1'b0;
		back_pri   = '0;
		back_color = '0;
		back_dot   = '0;
		reg_we     = 1'b0;
		reg_addr   = '0;
		reg_data   = '0;
		cyc        = 0;
		in_cyc     = 0;
		for (int i = 0; i < NUM_LAYERS; i++) pri_shadow[i] = '0;
		repeat (2) @(posedge CLK_6M);
		arst_n <= 1'b1;

		// distinct priorities for plain random and B transparent groups
		rewrite_priorities(3'd1, 3'd3, 3'd5, 3'd7);
		repeat_groups(MODE_RANDOM, 60);
		repeat_groups(MODE_B_ZERO, 30);
		// reversed order makes the first layers win
		rewrite_priorities(3'd7, 3'd5, 3'd3, 3'd1);
		repeat_groups(MODE_RANDOM, 60);
		// with all equal the later layers must never take a tie
		rewrite_priorities(3'd4, 3'd4, 3'd4, 3'd4);
		repeat_groups(MODE_RANDOM, 40);
		// with the layers off only the background reaches the output
		repeat_groups(MODE_BG, 30);
		rewrite_priorities(3'd2, 3'd6, 3'd1, 3'd5);
		repeat_groups(MODE_RANDOM, 30);

		// idle until every expected pixel has been compared
		while (time_q.size() != 0) begin
			drive_cycle('0, '0, 1'b0, '0, 1'b0, 2'd0, 8'd0);
		end
		$display("Testbench passed");
		$finish;
	end

endmodule

/* vlog.f */
source/tile_mixer_pkg.sv
source/tile_load_if.sv
source/load_sequencer.sv
source/plane_shifter.sv
source/priority_regs.sv
source/tilemap_pair.sv
source/tilemap_mixer_top.sv
testbench/tb_tilemap_mixer.sv

/* Makefile */
TOOL     := verilator
FLAGS    := --binary --timing
TOP      := tb_tilemap_mixer
FILELIST := vlog.f
OBJ_DIR  := obj_dir
PASS_MSG := Testbench passed

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with $(TOOL) and run the testbench"
	@echo "  clean  remove build output"
	@echo "  help   show this list"

$(OBJ_DIR)/V$(TOP): $(FILELIST)
	$(TOOL) $(FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

test: $(OBJ_DIR)/V$(TOP)
	./$(OBJ_DIR)/V$(TOP) | tee /dev/stderr | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
